// File: rtl/collatz_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// collatz search shared types
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package collatz_pkg;

  // datapath widths
  localparam int value_w = 32;
  localparam int step_w  = 16;
  localparam int count_w = 16;

  // search lanes
  localparam int lanes_n    = 4;
  localparam int lane_idx_w = (lanes_n > 1) ? $clog2(lanes_n) : 1;

  // a collatz value or a start value
  typedef logic [value_w-1:0] value_t;

  // steps taken by one start value
  typedef logic [step_w-1:0] step_t;

  // start values in one run
  typedef logic [count_w-1:0] count_t;

  typedef logic [lane_idx_w-1:0] lane_idx_t;

  // one bit per lane
  typedef logic [lanes_n-1:0] lane_mask_t;

  // finished search of one start value
  typedef struct packed {
    value_t start;
    step_t  steps;
    logic   overflow;
  } collatz_result_t;

  typedef enum logic [1:0] {
    lane_idle,
    lane_run,
    lane_done
  } lane_state_t;

endpackage

// File: rtl/start_dispatcher.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// start value dispatcher
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module start_dispatcher
  import collatz_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       go,
  input  value_t     start_base,
  input  count_t     start_count,
  input  lane_mask_t lane_idle,
  output lane_mask_t load,
  output value_t     load_value,
  output logic       run_start,
  output count_t     run_length
);

  value_t     next_value;
  count_t     remaining;
  logic       dispatching;
  lane_mask_t lowest_idle;

  // still start values left to hand out
  assign dispatching = (remaining != '0);

  // a new run is taken only once the last one is fully handed out
  assign run_start  = go && !dispatching;
  assign run_length = start_count;

  // isolate the lowest set idle bit
  assign lowest_idle = lane_idle & (~lane_idle + lane_mask_t'(1));

  // one lane per cycle at most
  assign load       = dispatching ? lowest_idle : '0;
  assign load_value = next_value;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      remaining <= '0;
    end
    else if (run_start)
    begin
      remaining <= start_count;
    end
    else if (|load)
    begin
      remaining <= remaining - 1'b1;
    end
  end

  // next start value to load
  always_ff @(posedge clk)
  begin
    if (run_start)
    begin
      next_value <= start_base;
    end
    else if (|load)
    begin
      next_value <= next_value + 1'b1;
    end
  end

endmodule

// File: rtl/collatz_lane.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// collatz search lane
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module collatz_lane
  import collatz_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  logic            load,
  input  value_t          load_value,
  input  logic            take,
  output logic            idle,
  output logic            done,
  output collatz_result_t result
);

  lane_state_t state;

  value_t cur_value;
  value_t start_value;
  step_t  step_count;
  logic   overflow;

  // two spare bits hold the carry out of 3n+1
  logic [value_w+1:0] tripled;
  value_t             next_value;
  logic               next_overflow;
  step_t              next_count;

  // one collatz step
  always_comb
  begin
    tripled       = {2'b00, cur_value} + {1'b0, cur_value, 1'b0} + 1'b1;
    next_overflow = 1'b0;
    if (cur_value[0])
    begin
      next_value    = tripled[value_w-1:0];
      next_overflow = |tripled[value_w+1:value_w];
    end
    else
    begin
      next_value = cur_value >> 1;
    end
    next_count = step_count + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= lane_idle;
    end
    else
    begin
      case (state)
        lane_idle:
        begin
          if (load)
          begin
            state <= lane_run;
          end
        end
        lane_run:
        begin
          // stopping time reached, or the value no longer fits
          if (next_overflow || (next_value < start_value))
          begin
            state <= lane_done;
          end
        end
        lane_done:
        begin
          if (take)
          begin
            state <= lane_idle;
          end
        end
        default:
        begin
          state <= lane_idle;
        end
      endcase
    end
  end

  // value, start and step counter
  always_ff @(posedge clk)
  begin
    if ((state == lane_idle) && load)
    begin
      cur_value   <= load_value;
      start_value <= load_value;
      step_count  <= '0;
      overflow    <= 1'b0;
    end
    else if (state == lane_run)
    begin
      cur_value  <= next_value;
      step_count <= next_count;
      overflow   <= next_overflow;
    end
  end

  assign idle = (state == lane_idle);
  assign done = (state == lane_done);

  // held stable while in done
  assign result = '{start: start_value, steps: step_count, overflow: overflow};

endmodule

// File: rtl/result_collector.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// result collector
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module result_collector
  import collatz_pkg::*;
(
  input  logic                          clk,
  input  logic                          reset,
  input  lane_mask_t                    lane_done,
  input  collatz_result_t [lanes_n-1:0] lane_results,
  input  logic                          run_start,
  input  count_t                        run_length,
  output lane_mask_t                    take,
  output logic                          busy,
  output logic                          result_valid,
  output collatz_result_t               result,
  output value_t                        record_start,
  output step_t                         record_steps
);

  lane_idx_t       last_idx;
  lane_idx_t       pick_idx;
  logic            pick_found;
  collatz_result_t picked;
  logic            better;
  count_t          taken_count;
  count_t          length_q;

  // round-robin search, starting after the lane taken last
  always_comb
  begin
    int idx;
    pick_found = 1'b0;
    pick_idx   = last_idx;
    for (int i = 1; i <= lanes_n; i++)
    begin
      idx = (int'(last_idx) + i) % lanes_n;
      if (!pick_found && lane_done[idx])
      begin
        pick_found = 1'b1;
        pick_idx   = lane_idx_t'(idx);
      end
    end
  end

  assign take   = pick_found ? (lane_mask_t'(1) << pick_idx) : '0;
  assign picked = lane_results[pick_idx];

  // more steps wins, ties go to the smaller start
  assign better = !picked.overflow &&
                  ((picked.steps > record_steps) ||
                   ((picked.steps == record_steps) && (picked.start < record_start)));

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      busy         <= 1'b0;
      result_valid <= 1'b0;
      last_idx     <= '0;
      taken_count  <= '0;
      length_q     <= '0;
      record_start <= '0;
      record_steps <= '0;
    end
    else
    begin
      result_valid <= pick_found;
      if (pick_found)
      begin
        last_idx <= pick_idx;
      end

      if (run_start)
      begin
        // an empty run never raises busy
        busy         <= (run_length != '0);
        length_q     <= run_length;
        taken_count  <= '0;
        record_start <= '0;
        record_steps <= '0;
      end
      else if (pick_found)
      begin
        taken_count <= taken_count + 1'b1;
        // busy drops together with the last result strobe
        if ((taken_count + 1'b1) == length_q)
        begin
          busy <= 1'b0;
        end
        if (better)
        begin
          record_start <= picked.start;
          record_steps <= picked.steps;
        end
      end
    end
  end

  // output register for the taken result
  always_ff @(posedge clk)
  begin
    if (pick_found)
    begin
      result <= picked;
    end
  end

endmodule

// File: rtl/collatz_search_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// collatz search engine
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module collatz_search_top
  import collatz_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  logic            go,
  input  value_t          start_base,
  input  count_t          start_count,
  output logic            busy,
  output logic            result_valid,
  output collatz_result_t result,
  output value_t          record_start,
  output step_t           record_steps
);

  lane_mask_t                    load;
  lane_mask_t                    lane_idle;
  lane_mask_t                    lane_done;
  lane_mask_t                    take;
  value_t                        load_value;
  logic                          run_start;
  count_t                        run_length;
  collatz_result_t [lanes_n-1:0] lane_results;

  // go is dropped while a run is in flight
  start_dispatcher i_start_dispatcher (
    .clk         (clk),
    .reset       (reset),
    .go          (go && !busy),
    .start_base  (start_base),
    .start_count (start_count),
    .lane_idle   (lane_idle),
    .load        (load),
    .load_value  (load_value),
    .run_start   (run_start),
    .run_length  (run_length)
  );

  for (genvar i = 0; i < lanes_n; i++)
  begin : g_lane
    collatz_lane i_collatz_lane (
      .clk        (clk),
      .reset      (reset),
      .load       (load[i]),
      .load_value (load_value),
      .take       (take[i]),
      .idle       (lane_idle[i]),
      .done       (lane_done[i]),
      .result     (lane_results[i])
    );
  end

  result_collector i_result_collector (
    .clk          (clk),
    .reset        (reset),
    .lane_done    (lane_done),
    .lane_results (lane_results),
    .run_start    (run_start),
    .run_length   (run_length),
    .take         (take),
    .busy         (busy),
    .result_valid (result_valid),
    .result       (result),
    .record_start (record_start),
    .record_steps (record_steps)
  );

endmodule

// File: tb/collatz_checker.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// collatz result checker
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module collatz_checker
  import collatz_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  logic            go,
  input  value_t          start_base,
  input  count_t          start_count,
  input  logic            busy,
  input  logic            result_valid,
  input  collatz_result_t result,
  input  value_t          record_start,
  input  step_t           record_steps,
  input  logic            pin_record,
  input  value_t          pinned_start,
  output int              error_count,
  output int              runs_done,
  output int              last_results,
  output int              last_flagged
);

  value_t run_base;
  count_t run_count;
  logic   active;
  logic   busy_q;
  logic   clear_check;
  int     results_in_run;
  int     flagged_in_run;
  // offsets into the run that already came back
  bit     seen [int];

  // stopping time in 64-bit arithmetic, overflow once 3n+1 leaves 32 bits
  function automatic collatz_result_t reference_result(input value_t s);
    logic [63:0]     v;
    logic [63:0]     t;
    int              steps;
    logic            ovf;
    logic            stop;
    collatz_result_t r;
    v     = {32'd0, s};
    steps = 0;
    ovf   = 1'b0;
    stop  = 1'b0;
    while (!stop)
    begin
      if (v[0])
      begin
        t = 64'd3 * v + 64'd1;
        if (t > 64'h0000_0000_ffff_ffff)
        begin
          ovf = 1'b1;
        end
        v = t;
      end
      else
      begin
        v = v >> 1;
      end
      steps++;
      if (ovf || (v < {32'd0, s}) || (steps >= 65535))
      begin
        stop = 1'b1;
      end
    end
    r.start    = s;
    r.steps    = step_t'(steps);
    r.overflow = ovf;
    return r;
  endfunction

  // more steps wins, equal steps go to the smaller start
  function automatic logic beats_record(input collatz_result_t r, input value_t rec_start,
                                        input step_t rec_steps);
    return !r.overflow && ((r.steps > rec_steps) ||
                           ((r.steps == rec_steps) && (r.start < rec_start)));
  endfunction

  task automatic report_error(input string msg);
    error_count++;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  task automatic check_result(input collatz_result_t r);
    value_t          offset;
    collatz_result_t expected;
    offset   = r.start - run_base;
    expected = reference_result(r.start);
    results_in_run++;
    if (r.overflow)
    begin
      flagged_in_run++;
    end
    if (!active)
    begin
      report_error($sformatf("result for start %0d outside a run", r.start));
    end
    else if (offset >= value_t'(run_count))
    begin
      report_error($sformatf("start %0d is not part of the run", r.start));
    end
    else if (seen.exists(int'(offset)))
    begin
      report_error($sformatf("start %0d came back twice", r.start));
    end
    else
    begin
      seen[int'(offset)] = 1'b1;
      if ((r.steps !== expected.steps) || (r.overflow !== expected.overflow))
      begin
        report_error($sformatf("start %0d: steps %0d ovf %0b, expected steps %0d ovf %0b",
                               r.start, r.steps, r.overflow, expected.steps,
                               expected.overflow));
      end
    end
  endtask

  // completeness and record once the last result is in
  task automatic finish_run;
    collatz_result_t r;
    value_t          exp_start;
    step_t           exp_steps;
    int              missing;
    exp_start = '0;
    exp_steps = '0;
    missing   = 0;
    for (int i = 0; i < int'(run_count); i++)
    begin
      if (!seen.exists(i))
      begin
        missing++;
      end
      r = reference_result(run_base + value_t'(i));
      if (beats_record(r, exp_start, exp_steps))
      begin
        exp_start = r.start;
        exp_steps = r.steps;
      end
    end
    if ((missing != 0) || (results_in_run != int'(run_count)))
    begin
      report_error($sformatf("%0d results for %0d starts, %0d missing",
                             results_in_run, run_count, missing));
    end
    if ((record_start !== exp_start) || (record_steps !== exp_steps))
    begin
      report_error($sformatf("record %0d/%0d steps, expected %0d/%0d steps",
                             record_start, record_steps, exp_start, exp_steps));
    end
    if (pin_record && (exp_start !== pinned_start))
    begin
      report_error($sformatf("record start %0d, expected %0d", exp_start, pinned_start));
    end
    last_results = results_in_run;
    last_flagged = flagged_in_run;
    runs_done++;
    active = 1'b0;
  endtask

  always @(posedge clk)
  begin
    if (reset)
    begin
      active      = 1'b0;
      busy_q      = 1'b0;
      clear_check = 1'b0;
    end
    else
    begin
      // one cycle after an accepted go
      if (clear_check)
      begin
        if (record_steps !== '0)
        begin
          report_error($sformatf("record steps %0d not cleared by go", record_steps));
        end
        if (busy !== 1'b1)
        begin
          report_error("busy did not rise after go");
        end
        clear_check = 1'b0;
      end
      if (result_valid)
      begin
        check_result(result);
      end
      // busy falls together with the last result strobe
      if (busy_q && !busy)
      begin
        finish_run;
      end
      if (go && !busy)
      begin
        run_base       = start_base;
        run_count      = start_count;
        results_in_run = 0;
        flagged_in_run = 0;
        seen.delete();
        active         = 1'b1;
        clear_check    = 1'b1;
      end
      busy_q = busy;
    end
  end

endmodule

// File: tb/tb_collatz_search.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// collatz search testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module tb_collatz_search
  import collatz_pkg::*;
();

  localparam int wait_limit = 100000;

  logic            clk;
  logic            reset;
  logic            go;
  value_t          start_base;
  count_t          start_count;
  logic            busy;
  logic            result_valid;
  collatz_result_t result;
  value_t          record_start;
  step_t           record_steps;

  logic   pin_record;
  value_t pinned_start;
  int     error_count;
  int     runs_done;
  int     last_results;
  int     last_flagged;

  integer seed;
  int     tests_run;
  int     tests_failed;
  bit     timed_out;

  initial
  begin
    clk = 1'b0;
  end

  always
  begin
    #4 clk = ~clk;
  end

  collatz_search_top i_collatz_search_top (
    .clk          (clk),
    .reset        (reset),
    .go           (go),
    .start_base   (start_base),
    .start_count  (start_count),
    .busy         (busy),
    .result_valid (result_valid),
    .result       (result),
    .record_start (record_start),
    .record_steps (record_steps)
  );

  collatz_checker i_collatz_checker (
    .clk          (clk),
    .reset        (reset),
    .go           (go),
    .start_base   (start_base),
    .start_count  (start_count),
    .busy         (busy),
    .result_valid (result_valid),
    .result       (result),
    .record_start (record_start),
    .record_steps (record_steps),
    .pin_record   (pin_record),
    .pinned_start (pinned_start),
    .error_count  (error_count),
    .runs_done    (runs_done),
    .last_results (last_results),
    .last_flagged (last_flagged)
  );

  // one-cycle go strobe, driven just after the clock edge
  task automatic pulse_go(input value_t base, input count_t count);
    @(posedge clk);
    #1;
    go          = 1'b1;
    start_base  = base;
    start_count = count;
    @(posedge clk);
    #1;
    go = 1'b0;
  endtask

  // go held high on every cycle the run is still busy
  task automatic hold_go_while_busy(input value_t base, input count_t count);
    int cycles;
    cycles      = 0;
    start_base  = base;
    start_count = count;
    while ((busy === 1'b1) && (cycles < wait_limit))
    begin
      go = 1'b1;
      @(posedge clk);
      #1;
      cycles++;
    end
    go = 1'b0;
    if (busy === 1'b1)
    begin
      $display("timeout: busy stayed high while go was held for %0d cycles", wait_limit);
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_for_busy(input logic level);
    int cycles;
    cycles = 0;
    while ((busy !== level) && (cycles < wait_limit))
    begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (busy !== level)
    begin
      $display("timeout: busy did not go %s within %0d cycles",
               level ? "high" : "low", wait_limit);
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_for_run_check(input int runs_before);
    int cycles;
    cycles = 0;
    while ((runs_done == runs_before) && (cycles < wait_limit))
    begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (runs_done == runs_before)
    begin
      $display("timeout: checker never closed the run");
      timed_out = 1'b1;
    end
  endtask

  task automatic run_test(input string name, input value_t base, input count_t count,
                          input logic pin, input value_t pinned, input logic extra_go);
    int errors_before;
    int runs_before;
    if (!timed_out)
    begin
      errors_before = error_count;
      runs_before   = runs_done;
      pin_record    = pin;
      pinned_start  = pinned;
      pulse_go(base, count);
      wait_for_busy(1'b1);
      if (extra_go && !timed_out)
      begin
        // covers the tail of the run too, after the last lane is loaded
        hold_go_while_busy(base + 32'd5000, count_t'(3));
      end
      if (!timed_out)
      begin
        wait_for_busy(1'b0);
      end
      if (!timed_out)
      begin
        wait_for_run_check(runs_before);
      end
      tests_run++;
      if (timed_out || (error_count != errors_before))
      begin
        tests_failed++;
        $display("test %-20s FAIL  %0d errors", name, error_count - errors_before);
      end
      else
      begin
        $display("test %-20s pass  %0d results, %0d flagged", name, last_results,
                 last_flagged);
      end
    end
  endtask

  initial
  begin
    value_t rand_base;
    count_t rand_count;
    go           = 1'b0;
    start_base   = '0;
    start_count  = '0;
    pin_record   = 1'b0;
    pinned_start = '0;
    reset        = 1'b1;
    seed         = 32'ha4db6ae9;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    repeat (2)
    begin
      @(posedge clk);
    end
    #1;
    reset = 1'b0;

    run_test("small range", 32'd2, count_t'(39), 1'b1, 32'd27, 1'b0);
    run_test("record 20..40", 32'd20, count_t'(21), 1'b1, 32'd27, 1'b0);
    // 7 and 15 both take 11 steps
    run_test("record tie 7..15", 32'd7, count_t'(9), 1'b1, 32'd7, 1'b0);
    run_test("overflow top", 32'hffff_fff0, count_t'(16), 1'b0, '0, 1'b0);
    // the first start overflows after 3 steps, the next odd one stops clean at 3
    run_test("overflow third", 32'h5555_5543, count_t'(29), 1'b1, 32'h5555_5545, 1'b0);
    run_test("go while busy", 32'd100, count_t'(20), 1'b0, '0, 1'b1);
    for (int n = 0; n < 5; n++)
    begin
      rand_base  = (value_t'($random(seed)) & 32'h0fff_ffff) + 32'd2;
      rand_count = count_t'(($random(seed) & 63) + 1);
      run_test($sformatf("random run %0d", n), rand_base, rand_count, 1'b0, '0, 1'b0);
    end

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if ((error_count == 0) && (tests_failed == 0) && !timed_out)
    begin
      $display("Done: no errors");
    end
    else
    begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: collatz_search.f
rtl/collatz_pkg.sv
rtl/start_dispatcher.sv
rtl/collatz_lane.sv
rtl/result_collector.sv
rtl/collatz_search_top.sv
tb/collatz_checker.sv
tb/tb_collatz_search.sv

// File: Makefile
TOP := tb_collatz_search
SIM := obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): collatz_search.f rtl/*.sv tb/*.sv
	verilator --binary --timing --top-module $(TOP) -f collatz_search.f

# the run passes only if the pass message shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "Done: no errors"

clean:
	rm -rf obj_dir
